/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wall
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_l1d
FILELIST   ?= tb.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* l1_data_mem.sv */
// --------------------------------------
// L1 line data store for one way
// Byte-lane writes, registered read
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module l1_data_mem (
	input  logic                         clk,
	input  logic                         en,
	input  logic                         we,
	input  logic [`L1_LINE_WIDTH/8-1:0]  be,
	input  logic [`L1_IDX_WIDTH-1:0]     idx,
	input  logic [`L1_LINE_WIDTH-1:0]    wdata,
	output logic [`L1_LINE_WIDTH-1:0]    rdata
);

	localparam int LINE_BYTES = `L1_LINE_WIDTH / 8;

	logic [LINE_BYTES-1:0][7:0] mem [`L1_SET_NUM];

	// Read returns the old line when written in the same cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int b = 0; b < LINE_BYTES; b++) begin
					if (be[b])
						mem[idx][b] <= wdata[b*8 +: 8];
				end
			end
			rdata <= mem[idx];
		end
	end

endmodule

/* l1_lru.sv */
// --------------------------------------
// L1 tag compare and replacement
// One LRU bit per set, two ways
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module l1_lru (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [`L1_IDX_WIDTH-1:0]        idx,
	input  logic [`L1_TAG_WIDTH-1:0]        req_tag,
	input  l1d_mem_pkg::tag_entry_s         entries [`L1_WAY_NUM],
	input  logic                            touch,
	input  logic [$clog2(`L1_WAY_NUM)-1:0]  touch_way,
	output logic                            hit,
	output logic [$clog2(`L1_WAY_NUM)-1:0]  hit_way,
	output logic [$clog2(`L1_WAY_NUM)-1:0]  victim_way
);
	import l1d_mem_pkg::*;

	localparam int WAY_W = $clog2(`L1_WAY_NUM);

	// Bit per set names the way used less recently
	logic [`L1_SET_NUM-1:0]  lru_bits;
	logic [`L1_WAY_NUM-1:0]  way_hit;
	logic                    any_free;
	logic [WAY_W-1:0]        free_way;

	always_comb begin
		hit      = 1'b0;
		hit_way  = '0;
		any_free = 1'b0;
		free_way = '0;
		for (int w = `L1_WAY_NUM - 1; w >= 0; w--) begin
			way_hit[w] = entries[w].val && (entries[w].tag == req_tag);
			if (way_hit[w]) begin
				hit     = 1'b1;
				hit_way = WAY_W'(w);
			end
			// Lowest invalid way wins
			if (!entries[w].val) begin
				any_free = 1'b1;
				free_way = WAY_W'(w);
			end
		end
	end

	assign victim_way = any_free ? free_way : lru_bits[idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lru_bits <= '0;
		else if (touch)
			lru_bits[idx] <= ~touch_way;
	end

	// A fill never duplicates a tag within a set
	a_onehot_hit: assert property (
		@(posedge clk) disable iff (!rst_n) touch |-> $onehot0(way_hit));

endmodule

/* l1_tag_mem.sv */
// --------------------------------------
// L1 tag store for one way
// Registered read, clears all sets
// with a sweep after reset
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module l1_tag_mem (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`L1_IDX_WIDTH-1:0]  idx,
	input  logic                      we,
	input  l1d_mem_pkg::tag_entry_s   wdata,
	output l1d_mem_pkg::tag_entry_s   rdata,
	output logic                      sweep_done
);
	import l1d_mem_pkg::*;

	tag_entry_s                mem [`L1_SET_NUM];
	logic [`L1_IDX_WIDTH-1:0]  sweep_cnt;
	logic                      wr_en;
	logic [`L1_IDX_WIDTH-1:0]  wr_idx;
	tag_entry_s                wr_data;

	// Sweep steps once per set, then hands the port over
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_cnt  <= '0;
			sweep_done <= 1'b0;
		end else if (!sweep_done) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == (`L1_SET_NUM - 1))
				sweep_done <= 1'b1;
		end
	end

	assign wr_en   = we || !sweep_done;
	assign wr_idx  = sweep_done ? idx : sweep_cnt;
	assign wr_data = sweep_done ? wdata : '0;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_idx] <= wr_data;
	end

	always_ff @(posedge clk) begin
		rdata <= mem[idx];
	end

	// Controller must hold off until every set is invalid
	a_no_write_in_sweep: assert property (
		@(posedge clk) disable iff (!rst_n) we |-> sweep_done);

endmodule

/* l1d_config.svh */
// --------------------------------------
// L1 data cache configuration
// Geometry and bus widths
// --------------------------------------
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Cache geometry
`define L1_WAY_NUM        2
`define L1_SET_NUM        16
`define L1_LINE_WIDTH     128

// Core bus widths
`define CORE_ADDR_WIDTH   32
`define CORE_DATA_WIDTH   32

// Address split, offset is in bytes within a line
`define L1_IDX_WIDTH      $clog2(`L1_SET_NUM)
`define L1_OFFSET_WIDTH   $clog2(`L1_LINE_WIDTH / 8)
`define L1_TAG_WIDTH      (`CORE_ADDR_WIDTH - `L1_IDX_WIDTH - `L1_OFFSET_WIDTH)

`endif

/* l1d_core_pkg.sv */
// --------------------------------------
// L1 data cache core-side types
// --------------------------------------
`include "l1d_config.svh"

package l1d_core_pkg;

	// Request opcodes
	typedef enum logic [1:0] {
		RD   = 2'd0,
		WR   = 2'd1,
		RDNC = 2'd2,
		WRNC = 2'd3
	} core_cop_e;

	// Access size
	typedef enum logic [1:0] {
		CORE_SIZE_BYTE = 2'd1,
		CORE_SIZE_HALF = 2'd2,
		CORE_SIZE_WORD = 2'd3
	} core_size_e;

	typedef struct packed {
		logic [`L1_TAG_WIDTH-1:0]    tag;
		logic [`L1_IDX_WIDTH-1:0]    idx;
		logic [`L1_OFFSET_WIDTH-1:0] offset;
	} l1_addr_fields_s;

	// Same address word, seen flat or split for the arrays
	typedef union packed {
		logic [`CORE_ADDR_WIDTH-1:0] flat;
		l1_addr_fields_s             f;
	} l1_addr_u;

	typedef struct packed {
		core_cop_e                   cop;
		l1_addr_u                    addr;
		logic [`CORE_DATA_WIDTH-1:0] wdata;
		core_size_e                  size;
	} core_req_s;

	typedef struct packed {
		logic [`CORE_DATA_WIDTH-1:0] rdata;
	} core_rsp_s;

endpackage

/* l1d_ctrl.sv */
// --------------------------------------
// L1 data cache controller
// One request at a time, write-through,
// no allocate on write
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module l1d_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              core_req_valid,
	output logic                              core_req_ready,
	input  l1d_core_pkg::core_req_s           core_req,
	output logic                              core_rsp_valid,
	output l1d_core_pkg::core_rsp_s           core_rsp,
	output logic                              mau_req_valid,
	input  logic                              mau_req_ready,
	output l1d_mem_pkg::mau_req_s             mau_req,
	input  logic                              mau_rsp_valid,
	input  l1d_mem_pkg::mau_rsp_s             mau_rsp,
	input  logic                              sweep_done,
	output logic [`L1_IDX_WIDTH-1:0]          arr_idx,
	output logic [`L1_WAY_NUM-1:0]            tag_we,
	output l1d_mem_pkg::tag_entry_s           tag_wdata,
	output logic [`L1_WAY_NUM-1:0]            data_en,
	output logic [`L1_WAY_NUM-1:0]            data_we,
	output logic [`L1_LINE_WIDTH/8-1:0]       data_be,
	output logic [`L1_LINE_WIDTH-1:0]         data_wdata,
	input  logic [`L1_LINE_WIDTH-1:0]         data_rdata [`L1_WAY_NUM],
	input  logic                              hit,
	input  logic [$clog2(`L1_WAY_NUM)-1:0]    hit_way,
	input  logic [$clog2(`L1_WAY_NUM)-1:0]    victim_way,
	output logic                              lru_touch,
	output logic [$clog2(`L1_WAY_NUM)-1:0]    lru_way
);
	import l1d_core_pkg::*;
	import l1d_mem_pkg::*;

	localparam int LINE_BYTES = `L1_LINE_WIDTH / 8;
	localparam int WORD_BYTES = `CORE_DATA_WIDTH / 8;
	localparam int WORDS      = `L1_LINE_WIDTH / `CORE_DATA_WIDTH;

	typedef enum logic [2:0] {
		IDLE, LOOKUP, COMPARE, MAU_REQ, MAU_WAIT, RESPOND
	} state_e;

	state_e                                state, state_nx;
	core_req_s                             req_q;
	logic [$clog2(`L1_WAY_NUM)-1:0]        victim_q;
	logic [`CORE_DATA_WIDTH-1:0]           rsp_data_q;
	logic                                  req_open;
	logic                                  is_wr, is_nc, rd_hit, wr_hit, need_mau, fill;
	logic [1:0]                            word_sel;
	logic [WORD_BYTES-1:0]                 word_be;
	logic [LINE_BYTES-1:0]                 line_be;
	logic [`CORE_DATA_WIDTH-1:0]           hit_word;

	// --------------------------------------
	// Request decode
	// --------------------------------------
	assign is_wr    = (req_q.cop == WR) || (req_q.cop == WRNC);
	assign is_nc    = (req_q.cop == RDNC) || (req_q.cop == WRNC);
	assign rd_hit   = (state == COMPARE) && !is_wr && !is_nc && hit;
	assign wr_hit   = (state == COMPARE) && is_wr && !is_nc && hit;
	assign need_mau = is_wr || is_nc || !hit;
	assign fill     = (state == MAU_WAIT) && mau_rsp_valid && !is_nc;
	assign word_sel = req_q.addr.f.offset[`L1_OFFSET_WIDTH-1:2];

	// Write data arrives lane-aligned within the word
	always_comb begin
		case (req_q.size)
			CORE_SIZE_BYTE: word_be = 4'b0001 << req_q.addr.f.offset[1:0];
			CORE_SIZE_HALF: word_be = 4'b0011 << req_q.addr.f.offset[1:0];
			default:        word_be = 4'b1111;
		endcase
	end

	assign line_be  = {{(LINE_BYTES-WORD_BYTES){1'b0}}, word_be} << {word_sel, 2'b00};
	assign hit_word = data_rdata[hit_way][word_sel*`CORE_DATA_WIDTH +: `CORE_DATA_WIDTH];

	// --------------------------------------
	// State machine
	// --------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			IDLE:     if (core_req_valid && core_req_ready) state_nx = LOOKUP;
			LOOKUP:   state_nx = COMPARE;
			COMPARE: begin
				if (!need_mau)
					state_nx = IDLE;
				else if (mau_req_ready)
					state_nx = is_wr ? RESPOND : MAU_WAIT;
				else
					state_nx = MAU_REQ;
			end
			MAU_REQ:  if (mau_req_ready) state_nx = is_wr ? RESPOND : MAU_WAIT;
			MAU_WAIT: if (mau_rsp_valid) state_nx = RESPOND;
			default:  state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			req_open <= 1'b0;
		end else begin
			state <= state_nx;
			if (core_req_valid && core_req_ready)
				req_open <= 1'b1;
			else if (core_rsp_valid)
				req_open <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (core_req_valid && core_req_ready)
			req_q <= core_req;
		if (state == COMPARE) begin
			victim_q   <= victim_way;
			rsp_data_q <= '0;
		end
		// MAU returns the whole line that holds the address
		if (state == MAU_WAIT && mau_rsp_valid)
			rsp_data_q <= mau_rsp.data[word_sel*`CORE_DATA_WIDTH +: `CORE_DATA_WIDTH];
	end

	// --------------------------------------
	// Array and LRU steering
	// --------------------------------------
	assign arr_idx   = req_q.addr.f.idx;
	assign tag_wdata = '{val: 1'b1, tag: req_q.addr.f.tag};

	always_comb begin
		tag_we     = '0;
		data_en    = '0;
		data_we    = '0;
		data_be    = line_be;
		data_wdata = {WORDS{req_q.wdata}};
		lru_touch  = 1'b0;
		lru_way    = hit_way;
		if (state == LOOKUP) begin
			data_en = '1;
		end else if (wr_hit) begin
			data_en[hit_way] = 1'b1;
			data_we[hit_way] = 1'b1;
			lru_touch        = 1'b1;
		end else if (rd_hit) begin
			lru_touch = 1'b1;
		end else if (fill) begin
			tag_we[victim_q]  = 1'b1;
			data_en[victim_q] = 1'b1;
			data_we[victim_q] = 1'b1;
			data_be           = '1;
			data_wdata        = mau_rsp.data;
			lru_touch         = 1'b1;
			lru_way           = victim_q;
		end
	end

	// --------------------------------------
	// Core and MAU outputs
	// --------------------------------------
	assign core_req_ready = (state == IDLE) && sweep_done;
	assign core_rsp_valid = rd_hit || (state == RESPOND);
	assign core_rsp.rdata = (state == COMPARE) ? hit_word : rsp_data_q;

	assign mau_req_valid = ((state == COMPARE) && need_mau) || (state == MAU_REQ);
	assign mau_req.we    = is_wr;
	assign mau_req.nc    = is_nc;
	// Line-aligned only for a cacheable read miss
	assign mau_req.addr  = (is_wr || is_nc) ? req_q.addr.flat :
		{req_q.addr.f.tag, req_q.addr.f.idx, {`L1_OFFSET_WIDTH{1'b0}}};
	assign mau_req.wdata = req_q.wdata;
	assign mau_req.be    = is_wr ? word_be : '1;

	// --------------------------------------
	// Assertions
	// --------------------------------------
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_valid && !core_req_ready |=> core_req_valid && $stable(core_req));

	a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_valid |->
			(core_req.size == CORE_SIZE_WORD) ? (core_req.addr.flat[1:0] == 2'b00) :
			(core_req.size == CORE_SIZE_HALF) ? !core_req.addr.flat[0] : 1'b1);

	a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		core_rsp_valid |-> req_open);

endmodule

/* l1d_mem_pkg.sv */
// --------------------------------------
// L1 data cache memory-side types
// MAU channel and tag store entry
// --------------------------------------
`include "l1d_config.svh"

package l1d_mem_pkg;

	// Request to the memory access unit
	typedef struct packed {
		logic                          we;
		logic                          nc;
		logic [`CORE_ADDR_WIDTH-1:0]   addr;
		logic [`CORE_DATA_WIDTH-1:0]   wdata;
		logic [`CORE_DATA_WIDTH/8-1:0] be;
	} mau_req_s;

	// Read response always carries a full line
	typedef struct packed {
		logic [`L1_LINE_WIDTH-1:0] data;
	} mau_rsp_s;

	// One tag store entry
	typedef struct packed {
		logic                     val;
		logic [`L1_TAG_WIDTH-1:0] tag;
	} tag_entry_s;

endpackage

/* l1d_top.sv */
// --------------------------------------
// L1 data cache top level
// Controller, per-way arrays and LRU
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module l1d_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     core_req_valid,
	output logic                     core_req_ready,
	input  l1d_core_pkg::core_req_s  core_req,
	output logic                     core_rsp_valid,
	output l1d_core_pkg::core_rsp_s  core_rsp,
	output logic                     mau_req_valid,
	input  logic                     mau_req_ready,
	output l1d_mem_pkg::mau_req_s    mau_req,
	input  logic                     mau_rsp_valid,
	input  l1d_mem_pkg::mau_rsp_s    mau_rsp
);
	import l1d_mem_pkg::*;

	logic [`L1_IDX_WIDTH-1:0]          arr_idx;
	logic [`L1_WAY_NUM-1:0]            tag_we;
	tag_entry_s                        tag_wdata;
	tag_entry_s                        tag_rdata [`L1_WAY_NUM];
	logic [`L1_WAY_NUM-1:0]            way_sweep_done;
	logic                              sweep_done;
	logic [`L1_WAY_NUM-1:0]            data_en;
	logic [`L1_WAY_NUM-1:0]            data_we;
	logic [`L1_LINE_WIDTH/8-1:0]       data_be;
	logic [`L1_LINE_WIDTH-1:0]         data_wdata;
	logic [`L1_LINE_WIDTH-1:0]         data_rdata [`L1_WAY_NUM];
	logic                              hit;
	logic [$clog2(`L1_WAY_NUM)-1:0]    hit_way;
	logic [$clog2(`L1_WAY_NUM)-1:0]    victim_way;
	logic                              lru_touch;
	logic [$clog2(`L1_WAY_NUM)-1:0]    lru_way;

	// Ready only once every way has been cleared
	assign sweep_done = &way_sweep_done;

	l1d_ctrl l1d_ctrl_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_valid (core_req_valid),
		.core_req_ready (core_req_ready),
		.core_req       (core_req),
		.core_rsp_valid (core_rsp_valid),
		.core_rsp       (core_rsp),
		.mau_req_valid  (mau_req_valid),
		.mau_req_ready  (mau_req_ready),
		.mau_req        (mau_req),
		.mau_rsp_valid  (mau_rsp_valid),
		.mau_rsp        (mau_rsp),
		.sweep_done     (sweep_done),
		.arr_idx        (arr_idx),
		.tag_we         (tag_we),
		.tag_wdata      (tag_wdata),
		.data_en        (data_en),
		.data_we        (data_we),
		.data_be        (data_be),
		.data_wdata     (data_wdata),
		.data_rdata     (data_rdata),
		.hit            (hit),
		.hit_way        (hit_way),
		.victim_way     (victim_way),
		.lru_touch      (lru_touch),
		.lru_way        (lru_way)
	);

	// Tag compare uses the registered request tag
	l1_lru l1_lru_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.idx        (arr_idx),
		.req_tag    (tag_wdata.tag),
		.entries    (tag_rdata),
		.touch      (lru_touch),
		.touch_way  (lru_way),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way)
	);

	for (genvar w = 0; w < `L1_WAY_NUM; w++) begin : g_way
		l1_tag_mem l1_tag_mem_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.idx        (arr_idx),
			.we         (tag_we[w]),
			.wdata      (tag_wdata),
			.rdata      (tag_rdata[w]),
			.sweep_done (way_sweep_done[w])
		);

		l1_data_mem l1_data_mem_i (
			.clk   (clk),
			.en    (data_en[w]),
			.we    (data_we[w]),
			.be    (data_be),
			.idx   (arr_idx),
			.wdata (data_wdata),
			.rdata (data_rdata[w])
		);
	end

endmodule

/* tb.f */
+incdir+.
l1d_core_pkg.sv
l1d_mem_pkg.sv
l1_tag_mem.sv
l1_data_mem.sv
l1_lru.sv
l1d_ctrl.sv
l1d_top.sv
tb_l1d_mem.sv
tb_l1d.sv

/* tb_l1d.sv */
// --------------------------------------
// Testbench for the L1 data cache
// Directed and random requests, checked
// by concurrent assertions on a tag model
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module tb_l1d;
	import l1d_core_pkg::*;
	import l1d_mem_pkg::*;

	// Requests times worst MAU delay, plus reset and sweep
	localparam int REQ_NUM = 230;
	localparam int TIMEOUT = REQ_NUM * 17 + `L1_SET_NUM + 20;

	typedef struct packed {
		logic        fast;
		logic        we;
		logic        nc;
		logic [31:0] maddr;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic [31:0] rdata;
	} expect_s;

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	logic       core_req_valid = 1'b0;
	logic       core_req_ready;
	core_req_s  core_req = '0;
	logic       core_rsp_valid;
	core_rsp_s  core_rsp;
	logic       mau_req_valid;
	logic       mau_req_ready;
	mau_req_s   mau_req;
	logic       mau_rsp_valid;
	mau_rsp_s   mau_rsp;
	logic [2:0] mau_delay = '0;

	expect_s     exp_q = '0;
	int          err_cnt = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;
	int          post_cnt = 0;
	logic [31:0] lfsr_state = 32'h058b_0281;

	// Tag model, two ways per set
	logic [23:0] m_tag [16][2];
	logic        m_val [16][2];
	logic        m_lru [16];
	logic [31:0] ref_mem [logic [29:0]];

	always #2 clk = ~clk;

	l1d_top l1d_top_i (
		.clk(clk), .rst_n(rst_n),
		.core_req_valid(core_req_valid), .core_req_ready(core_req_ready), .core_req(core_req),
		.core_rsp_valid(core_rsp_valid), .core_rsp(core_rsp),
		.mau_req_valid(mau_req_valid), .mau_req_ready(mau_req_ready), .mau_req(mau_req),
		.mau_rsp_valid(mau_rsp_valid), .mau_rsp(mau_rsp)
	);

	tb_l1d_mem mem_i (
		.clk(clk), .rst_n(rst_n), .delay(mau_delay),
		.mau_req_valid(mau_req_valid), .mau_req_ready(mau_req_ready), .mau_req(mau_req),
		.mau_rsp_valid(mau_rsp_valid), .mau_rsp(mau_rsp)
	);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			post_cnt <= 0;
		else if (post_cnt < 255)
			post_cnt <= post_cnt + 1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Timeout: no progress after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// --------------------------------------
	// Checks
	// --------------------------------------
	a_sweep_quiet: assert property (@(posedge clk)
		(!rst_n || post_cnt < `L1_SET_NUM) |->
			!core_req_ready && !core_rsp_valid && !mau_req_valid)
		else begin
			err_cnt++;
			$display("Cache not quiet during reset sweep at %0t", $time);
		end

	a_sweep_ready: assert property (@(posedge clk) disable iff (!rst_n)
		post_cnt == `L1_SET_NUM |-> core_req_ready)
		else begin
			err_cnt++;
			$display("Error %0t core_req_ready got 0 expected 1", $time);
		end

	a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_valid && core_req_ready && exp_q.fast |->
			##1 (!core_rsp_valid && !mau_req_valid) ##1 (core_rsp_valid && !mau_req_valid))
		else begin
			err_cnt++;
			$display("Read hit not answered 2 cycles after acceptance at %0t", $time);
		end

	a_miss_path: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_valid && core_req_ready && !exp_q.fast |->
			##2 (mau_req_valid && !core_rsp_valid))
		else begin
			err_cnt++;
			$display("Expected MAU request missing at %0t", $time);
		end

	a_mau_addr: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_valid |-> mau_req.addr == exp_q.maddr)
		else begin
			err_cnt++;
			$display("Error %0t mau_req.addr got %h expected %h", $time,
				$sampled(mau_req.addr), $sampled(exp_q.maddr));
		end

	a_mau_kind: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_valid |-> mau_req.we == exp_q.we && mau_req.nc == exp_q.nc)
		else begin
			err_cnt++;
			$display("Error %0t mau_req.we/nc got %b%b expected %b%b", $time,
				$sampled(mau_req.we), $sampled(mau_req.nc),
				$sampled(exp_q.we), $sampled(exp_q.nc));
		end

	a_mau_write: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_valid && exp_q.we |-> mau_req.wdata == exp_q.wdata && mau_req.be == exp_q.be)
		else begin
			err_cnt++;
			$display("Error %0t mau_req.wdata/be got %h/%b expected %h/%b", $time,
				$sampled(mau_req.wdata), $sampled(mau_req.be),
				$sampled(exp_q.wdata), $sampled(exp_q.be));
		end

	a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
		core_rsp_valid |-> core_rsp.rdata == exp_q.rdata)
		else begin
			err_cnt++;
			$display("Error %0t core_rsp.rdata got %h expected %h", $time,
				$sampled(core_rsp.rdata), $sampled(exp_q.rdata));
		end

	// --------------------------------------
	// Stimulus helpers
	// --------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] init_pattern(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] a);
		if (ref_mem.exists(a[31:2]))
			return ref_mem[a[31:2]];
		return init_pattern({a[31:2], 2'b00});
	endfunction

	// Updates the models, then runs one request to its response
	task automatic issue(input core_cop_e cop, input logic [31:0] addr,
			input logic [31:0] wdata, input core_size_e size);
		logic [3:0]  be;
		logic        hit;
		logic        way;
		logic        victim;
		logic [3:0]  idx;
		logic [31:0] word;
		expect_s     e;
		idx = addr[7:4];
		case (size)
			CORE_SIZE_BYTE: be = 4'b0001 << addr[1:0];
			CORE_SIZE_HALF: be = 4'b0011 << addr[1:0];
			default:        be = 4'b1111;
		endcase
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++)
			if (m_val[idx][w] && m_tag[idx][w] == addr[31:8]) begin
				hit = 1'b1;
				way = w[0];
			end
		e.fast  = (cop == RD) && hit;
		e.we    = (cop == WR) || (cop == WRNC);
		e.nc    = (cop == RDNC) || (cop == WRNC);
		e.maddr = (cop == RD) ? {addr[31:4], 4'h0} : addr;
		e.wdata = wdata;
		e.be    = be;
		word    = ref_word(addr);
		e.rdata = e.we ? 32'h0 : word;
		if (cop == RD && !hit) begin
			victim = !m_val[idx][0] ? 1'b0 : !m_val[idx][1] ? 1'b1 : m_lru[idx];
			m_val[idx][victim] = 1'b1;
			m_tag[idx][victim] = addr[31:8];
			m_lru[idx] = ~victim;
		end else if ((cop == RD || cop == WR) && hit) begin
			m_lru[idx] = ~way;
		end
		if (e.we) begin
			for (int b = 0; b < 4; b++)
				if (be[b])
					word[b*8 +: 8] = wdata[b*8 +: 8];
			ref_mem[addr[31:2]] = word;
		end
		exp_q          = e;
		mau_delay      = 3'(rand_bits(3));
		core_req.cop   = cop;
		core_req.addr  = addr;
		core_req.wdata = wdata;
		core_req.size  = size;
		core_req_valid = 1'b1;
		while (!core_req_ready)
			@(negedge clk);
		@(negedge clk);
		core_req_valid = 1'b0;
		while (!core_rsp_valid)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt != errs_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_cnt - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// --------------------------------------
	// Tests
	// --------------------------------------
	initial begin
		int          e0;
		logic [31:0] a;
		logic [1:0]  s;
		logic [2:0]  tg;
		logic [1:0]  st;
		logic [3:0]  off;
		core_cop_e   cop;
		for (int i = 0; i < 16; i++) begin
			m_val[i][0] = 1'b0;
			m_val[i][1] = 1'b0;
			m_tag[i][0] = '0;
			m_tag[i][1] = '0;
			m_lru[i]    = 1'b0;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		e0 = err_cnt;
		while (post_cnt < `L1_SET_NUM + 4)
			@(negedge clk);
		finish_test("reset_sweep", e0);

		e0 = err_cnt;
		issue(RD, 32'h0000_0104, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_0104, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_010c, 32'h0, CORE_SIZE_WORD);
		finish_test("read_miss_hit", e0);

		e0 = err_cnt;
		issue(WR, 32'h0000_0109, 32'h0000_ab00, CORE_SIZE_BYTE);
		issue(RD, 32'h0000_0108, 32'h0, CORE_SIZE_WORD);
		issue(WR, 32'h0000_0226, 32'h1234_0000, CORE_SIZE_HALF);
		issue(RD, 32'h0000_0224, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_0224, 32'h0, CORE_SIZE_WORD);
		finish_test("write_through", e0);

		e0 = err_cnt;
		issue(WRNC, 32'h1000_0034, 32'hcafe_f00d, CORE_SIZE_WORD);
		issue(RDNC, 32'h1000_0034, 32'h0, CORE_SIZE_WORD);
		issue(RDNC, 32'h1000_0034, 32'h0, CORE_SIZE_WORD);
		finish_test("non_cacheable", e0);

		// Set 15 is left alone by the other tests
		e0 = err_cnt;
		issue(RD, 32'h0000_01f0, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_02f0, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_01f0, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_03f0, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_01f0, 32'h0, CORE_SIZE_WORD);
		issue(RD, 32'h0000_02f0, 32'h0, CORE_SIZE_WORD);
		finish_test("lru_replace", e0);

		e0 = err_cnt;
		for (int n = 0; n < 200; n++) begin
			cop = core_cop_e'(2'(rand_bits(2)));
			s   = 2'(rand_bits(2));
			if (s == 2'd0)
				s = 2'd3;
			// Tags 1 to 4 over sets 0 to 3, uncached traffic kept apart
			tg  = 3'(rand_bits(2)) + 3'd1;
			st  = 2'(rand_bits(2));
			off = 4'(rand_bits(4));
			a   = {21'h0, tg, 2'b00, st, off};
			if (cop == RDNC || cop == WRNC)
				a[28] = 1'b1;
			if (s == 2'd3)
				a[1:0] = 2'b00;
			else if (s == 2'd2)
				a[0] = 1'b0;
			issue(cop, a, rand_bits(32), core_size_e'(s));
		end
		finish_test("random_mix", e0);

		repeat (4) @(negedge clk);
		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* tb_l1d_mem.sv */
// --------------------------------------
// Behavioral MAU model for the L1 cache
// Programmable ready delay, fixed read
// latency, shadow memory of words
// --------------------------------------
`timescale 1ns/10ps
`include "l1d_config.svh"

module tb_l1d_mem (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [2:0]             delay,
	input  logic                   mau_req_valid,
	output logic                   mau_req_ready,
	input  l1d_mem_pkg::mau_req_s  mau_req,
	output logic                   mau_rsp_valid = 1'b0,
	output l1d_mem_pkg::mau_rsp_s  mau_rsp = '0
);
	import l1d_mem_pkg::*;

	logic [31:0] shadow [logic [29:0]];
	logic [2:0]  wait_cnt = '0;
	logic [1:0]  pend_lat = '0;
	logic [31:0] line_addr = '0;
	logic        took = 1'b0;
	mau_req_s    took_req = '0;

	// Unwritten words hold a pattern of their own address
	function automatic logic [31:0] init_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (shadow.exists(a[31:2]))
			return shadow[a[31:2]];
		return init_word({a[31:2], 2'b00});
	endfunction

	assign mau_req_ready = (wait_cnt >= delay);

	// Handshake is taken at the same edge as in the DUT
	always @(posedge clk) begin
		took     <= mau_req_valid && mau_req_ready;
		took_req <= mau_req;
	end

	// Ready count and responses move on the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			wait_cnt      <= '0;
			pend_lat      <= '0;
			mau_rsp_valid <= 1'b0;
		end else begin
			mau_rsp_valid <= 1'b0;
			if (mau_req_valid)
				wait_cnt <= wait_cnt + 1'b1;
			else
				wait_cnt <= '0;
			if (pend_lat == 2'd1) begin
				mau_rsp_valid <= 1'b1;
				for (int w = 0; w < 4; w++)
					mau_rsp.data[w*32 +: 32] <= read_word(line_addr + 32'(w * 4));
			end
			if (pend_lat != 0)
				pend_lat <= pend_lat - 1'b1;
			if (took) begin
				if (took_req.we) begin
					logic [31:0] word;
					word = read_word(took_req.addr);
					for (int b = 0; b < 4; b++)
						if (took_req.be[b])
							word[b*8 +: 8] = took_req.wdata[b*8 +: 8];
					shadow[took_req.addr[31:2]] = word;
				end else begin
					pend_lat  <= 2'd2;
					line_addr <= {took_req.addr[31:4], 4'h0};
				end
			end
		end
	end

endmodule
